// File: all.f
+incdir+test
hdl/fifo_pkg.sv
hdl/wb_pkg.sv
hdl/cdc_sync.sv
hdl/wb_access_fsm.sv
hdl/write_pointer.sv
hdl/read_pointer.sv
hdl/fifo_mem.sv
hdl/async_fifo_wb.sv
test/tb_async_fifo.sv

// File: hdl/async_fifo_wb.sv
`timescale 1ns/1ns

module async_fifo_wb
	import fifo_pkg::*;
	import wb_pkg::*;
#(
	parameter int DEPTH = 8,
	localparam int ADDR_WIDTH = $clog2(DEPTH)
)
(
	input  logic    write_clk,
	input  logic    read_clk,
	input  logic    reset_rsync,
	input  wb_req_t wr_req,
	output wb_rsp_t wr_rsp,
	input  wb_req_t rd_req,
	output wb_rsp_t rd_rsp,
	output logic    full,
	output logic    empty
);

	logic                  read_reset;
	logic                  push;
	logic                  pop;
	logic                  wr_ack;
	logic                  rd_ack;
	logic [ADDR_WIDTH:0]   wr_gray;
	logic [ADDR_WIDTH:0]   rd_gray;
	logic [ADDR_WIDTH:0]   wr_gray_sync;
	logic [ADDR_WIDTH:0]   rd_gray_sync;
	logic [ADDR_WIDTH-1:0] wr_addr;
	logic [ADDR_WIDTH-1:0] rd_addr;
	fifo_word_t            rd_word;

	//////////////////////////////
	// write domain
	//////////////////////////////

	wb_access_fsm wr_fsm (
		.clk   (write_clk),
		.reset (reset_rsync),
		.req   (wr_req),
		.ready (!full),
		.op    (push),
		.ack   (wr_ack)
	);

	write_pointer #(.DEPTH(DEPTH)) wr_ptr (
		.clk          (write_clk),
		.reset        (reset_rsync),
		.push         (push),
		.rd_gray_sync (rd_gray_sync),
		.wr_gray      (wr_gray),
		.wr_addr      (wr_addr),
		.full         (full)
	);

	cdc_sync #(.WIDTH(ADDR_WIDTH + 1)) rd_gray_to_wr (
		.clk      (write_clk),
		.reset    (reset_rsync),
		.data_in  (rd_gray),
		.data_out (rd_gray_sync)
	);

	// write port never returns data
	assign wr_rsp = '{ack: wr_ack, dat: '0};

	//////////////////////////////
	// read domain
	//////////////////////////////

	// local reset, released two read_clk edges after the external one
	cdc_sync #(.WIDTH(1), .RESET_VALUE(1'b1)) read_reset_sync (
		.clk      (read_clk),
		.reset    (reset_rsync),
		.data_in  (1'b0),
		.data_out (read_reset)
	);

	cdc_sync #(.WIDTH(ADDR_WIDTH + 1)) wr_gray_to_rd (
		.clk      (read_clk),
		.reset    (read_reset),
		.data_in  (wr_gray),
		.data_out (wr_gray_sync)
	);

	wb_access_fsm rd_fsm (
		.clk   (read_clk),
		.reset (read_reset),
		.req   (rd_req),
		.ready (!empty),
		.op    (pop),
		.ack   (rd_ack)
	);

	read_pointer #(.DEPTH(DEPTH)) rd_ptr (
		.clk          (read_clk),
		.reset        (read_reset),
		.pop          (pop),
		.wr_gray_sync (wr_gray_sync),
		.rd_gray      (rd_gray),
		.rd_addr      (rd_addr),
		.empty        (empty)
	);

	fifo_mem #(.DEPTH(DEPTH)) mem (
		.write_clk (write_clk),
		.wr_en     (push),
		.wr_addr   (wr_addr),
		.wr_data   (wr_req.dat),
		.read_clk  (read_clk),
		.rd_en     (pop),
		.rd_addr   (rd_addr),
		.rd_data   (rd_word)
	);

	assign rd_rsp = '{ack: rd_ack, dat: rd_word};

endmodule

// File: hdl/cdc_sync.sv
`timescale 1ns/1ns

module cdc_sync
	import fifo_pkg::*;
#(
	parameter int WIDTH = 1,
	parameter logic [WIDTH-1:0] RESET_VALUE = '0
)
(
	input  logic             clk,
	input  logic             reset,
	input  logic [WIDTH-1:0] data_in,
	output logic [WIDTH-1:0] data_out
);

	// stage 0 may go metastable, later stages settle it
	logic [SYNC_STAGES-1:0][WIDTH-1:0] chain;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			chain <= {SYNC_STAGES{RESET_VALUE}};
		end
		else
		begin
			chain <= {chain[SYNC_STAGES-2:0], data_in};
		end
	end

	assign data_out = chain[SYNC_STAGES-1];

endmodule

// File: hdl/fifo_mem.sv
`timescale 1ns/1ns

module fifo_mem
	import fifo_pkg::*;
#(
	parameter int DEPTH = 8,
	localparam int ADDR_WIDTH = $clog2(DEPTH)
)
(
	input  logic                  write_clk,
	input  logic                  wr_en,
	input  logic [ADDR_WIDTH-1:0] wr_addr,
	input  fifo_word_t            wr_data,
	input  logic                  read_clk,
	input  logic                  rd_en,
	input  logic [ADDR_WIDTH-1:0] rd_addr,
	output fifo_word_t            rd_data
);

	fifo_word_t storage [DEPTH];

	always_ff @(posedge write_clk)
	begin
		if (wr_en)
		begin
			storage[wr_addr] <= wr_data;
		end
	end

	// word is captured at the pop edge, valid during ack
	always_ff @(posedge read_clk)
	begin
		if (rd_en)
		begin
			rd_data <= storage[rd_addr];
		end
	end

endmodule

// File: hdl/fifo_pkg.sv
package fifo_pkg;

	//////////////////////////////
	// payload
	//////////////////////////////

	// width of one stored word
	parameter int DATA_WIDTH = 32;

	typedef logic [DATA_WIDTH-1:0] fifo_word_t;

	//////////////////////////////
	// clock domain crossing
	//////////////////////////////

	// flops in every synchronizer chain
	parameter int SYNC_STAGES = 2;

	// bus access state machine, one transfer in flight at most
	typedef enum logic
	{
		ACCESS_IDLE = 1'b0,
		ACCESS_ACK  = 1'b1
	} access_state_t;

endpackage

// File: hdl/read_pointer.sv
`timescale 1ns/1ns

module read_pointer
#(
	parameter int DEPTH = 8,
	localparam int ADDR_WIDTH = $clog2(DEPTH)
)
(
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  pop,
	input  logic [ADDR_WIDTH:0]   wr_gray_sync,
	output logic [ADDR_WIDTH:0]   rd_gray,
	output logic [ADDR_WIDTH-1:0] rd_addr,
	output logic                  empty
);

	logic [ADDR_WIDTH:0] rd_bin;
	logic [ADDR_WIDTH:0] rd_bin_inc;
	logic [ADDR_WIDTH:0] rd_gray_inc;

	assign rd_bin_inc  = rd_bin + 1'b1;
	assign rd_gray_inc = rd_bin_inc ^ (rd_bin_inc >> 1);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			rd_bin  <= '0;
			rd_gray <= '0;
		end
		else if (pop)
		begin
			rd_bin  <= rd_bin_inc;
			rd_gray <= rd_gray_inc;
		end
	end

	// synced write pointer lags, so empty may clear late but never early
	assign empty = (rd_gray == wr_gray_sync);

	assign rd_addr = rd_bin[ADDR_WIDTH-1:0];

endmodule

// File: hdl/wb_access_fsm.sv
`timescale 1ns/1ns

module wb_access_fsm
	import fifo_pkg::*;
	import wb_pkg::*;
(
	input  logic    clk,
	input  logic    reset,
	input  wb_req_t req,
	input  logic    ready,
	output logic    op,
	output logic    ack
);

	access_state_t state;
	logic          request;

	//////////////////////////////
	// request decode
	//////////////////////////////

	// we is ignored, each port only moves data one way
	assign request = req.cyc && req.stb;

	// push or pop commits at the edge that ends this cycle
	assign op = (state == ACCESS_IDLE) && request && ready;

	// ack follows one cycle after the op strobe
	assign ack = (state == ACCESS_ACK);

	//////////////////////////////
	// state register
	//////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= ACCESS_IDLE;
		end
		else
		begin
			case (state)
				ACCESS_IDLE:
				begin
					// held off with ack low while ready is low
					if (op)
					begin
						state <= ACCESS_ACK;
					end
				end
				ACCESS_ACK:
				begin
					// master drops stb after seeing ack
					state <= ACCESS_IDLE;
				end
				default:
				begin
					state <= ACCESS_IDLE;
				end
			endcase
		end
	end

endmodule

// File: hdl/wb_pkg.sv
package wb_pkg;

	import fifo_pkg::*;

	//////////////////////////////
	// wishbone classic
	//////////////////////////////

	// master to slave, one register per port so no address or select
	typedef struct packed
	{
		logic       cyc;
		logic       stb;
		logic       we;
		fifo_word_t dat;
	} wb_req_t;

	// slave to master
	typedef struct packed
	{
		logic       ack;
		fifo_word_t dat;
	} wb_rsp_t;

	// no err line, a request is either served or held off

endpackage

// File: hdl/write_pointer.sv
`timescale 1ns/1ns

module write_pointer
#(
	parameter int DEPTH = 8,
	localparam int ADDR_WIDTH = $clog2(DEPTH)
)
(
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  push,
	input  logic [ADDR_WIDTH:0]   rd_gray_sync,
	output logic [ADDR_WIDTH:0]   wr_gray,
	output logic [ADDR_WIDTH-1:0] wr_addr,
	output logic                  full
);

	// extra top bit counts laps around the array
	logic [ADDR_WIDTH:0] wr_bin;
	logic [ADDR_WIDTH:0] wr_bin_inc;
	logic [ADDR_WIDTH:0] wr_gray_inc;
	logic [ADDR_WIDTH:0] wr_gray_next;
	logic [ADDR_WIDTH:0] lap_diff;

	assign wr_bin_inc  = wr_bin + 1'b1;
	assign wr_gray_inc = wr_bin_inc ^ (wr_bin_inc >> 1);

	// pointer value after this edge, push is never high while full
	assign wr_gray_next = push ? wr_gray_inc : wr_gray;

	//////////////////////////////
	// full detection
	//////////////////////////////

	// one lap ahead in gray: top two bits differ, the rest match
	assign lap_diff = wr_gray_next ^ rd_gray_sync;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wr_bin  <= '0;
			wr_gray <= '0;
			full    <= 1'b0;
		end
		else
		begin
			if (push)
			begin
				wr_bin  <= wr_bin_inc;
				wr_gray <= wr_gray_inc;
			end
			full <= lap_diff[ADDR_WIDTH] && lap_diff[ADDR_WIDTH-1]
				&& (lap_diff[ADDR_WIDTH-2:0] == '0);
		end
	end

	assign wr_addr = wr_bin[ADDR_WIDTH-1:0];

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the async FIFO testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f all.f --top-module tb_async_fifo
./obj_dir/Vtb_async_fifo > sim.log
cat sim.log
if grep -q "TESTBENCH PASSED" sim.log
then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

// File: test/fifo_stim.txt
# columns: test name, command, hex data word or hex count
# a read names the word it expects, drain 0 empties the FIFO
reset_idle          idle-check  8
order_write_a       write       00000001
order_write_b       write       deadbeef
order_write_c       write       a5a5a5a5
order_read_a        read        00000001
order_read_b        read        deadbeef
order_write_d       write       ffffffff
order_write_e       write       12345678
order_read_c        read        a5a5a5a5
order_read_d        read        ffffffff
order_write_f       write       80000000
order_read_e        read        12345678
order_read_f        read        80000000
order_settle        idle-check  6
full_fill           fill        8
full_hold           idle-check  4
full_stall_write    write       cafe0001
wrap_drain          drain       9
empty_after_drain   idle-check  6
empty_stall_read    read        5a5a5a5a
random_mix_a        random      40
random_mix_b        random      40
random_mix_c        random      30
random_flush        drain       0
final_idle          idle-check  8

// File: test/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

//////////////////////////////
// result compares
//////////////////////////////

// popped or returned payload word
task automatic check_word(input string name, input fifo_word_t expected,
	input fifo_word_t actual);
	if (actual !== expected)
	begin
		$display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
		error_count++;
	end
endtask

// status flag or ack level
task automatic check_flag(input string name, input string what, input logic expected,
	input logic actual);
	if (actual !== expected)
	begin
		$display("MISMATCH %s: %s expected %b, actual %b", name, what, expected, actual);
		error_count++;
	end
endtask

//////////////////////////////
// random data
//////////////////////////////

// fibonacci lfsr, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
	logic feedback;
	feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
	return {state[30:0], feedback};
endfunction

// one lfsr step per bit taken
function automatic logic [31:0] random_bits(input int count);
	logic [31:0] bits;
	bits = '0;
	for (int i = 0; i < count; i++)
	begin
		lfsr_state = lfsr_next(lfsr_state);
		bits = {bits[30:0], lfsr_state[31]};
	end
	return bits;
endfunction

`endif

// File: test/tb_async_fifo.sv
`timescale 1ns/1ns

module tb_async_fifo
	import fifo_pkg::*;
	import wb_pkg::*;
();

	localparam int DEPTH = 8;
	localparam int WRITE_PERIOD = 100;
	localparam int READ_PERIOD = 140;
	localparam int DRIVE_DELAY = 10;
	localparam int RESET_CYCLES = 3;
	localparam int STALL_CYCLES = 10;
	localparam int FLAG_BOUND = 4;
	localparam string STIM_FILE = "test/fifo_stim.txt";

	logic       write_clk;
	logic       read_clk;
	logic       reset_rsync;
	wb_req_t    wr_req;
	wb_req_t    rd_req;
	wb_rsp_t    wr_rsp;
	wb_rsp_t    rd_rsp;
	logic       full;
	logic       empty;
	int         error_count = 0;
	int         cycle_count = 0;
	int         cycle_limit = 0;
	int         total_ops = 0;
	logic [31:0] lfsr_state = 32'h84c2_37ac;
	fifo_word_t ref_queue[$];
	string      stim_names[$];
	string      stim_cmds[$];
	fifo_word_t stim_values[$];

	`include "tb_checks.svh"

	async_fifo_wb #(.DEPTH(DEPTH)) uut (
		.write_clk   (write_clk),
		.read_clk    (read_clk),
		.reset_rsync (reset_rsync),
		.wr_req      (wr_req),
		.wr_rsp      (wr_rsp),
		.rd_req      (rd_req),
		.rd_rsp      (rd_rsp),
		.full        (full),
		.empty       (empty)
	);

	initial
	begin
		write_clk = 1'b0;
		read_clk  = 1'b0;
	end

	always #(WRITE_PERIOD / 2) write_clk = ~write_clk;

	always #(READ_PERIOD / 2) read_clk = ~read_clk;

	// limit is set once the stimulus file is counted
	always @(posedge write_clk)
	begin
		cycle_count++;
		if (cycle_limit > 0 && cycle_count >= cycle_limit)
		begin
			$display("timeout: no progress within %0d write_clk cycles", cycle_limit);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	//////////////////////////////
	// bus transfers
	//////////////////////////////

	task automatic start_write(input fifo_word_t data);
		@(posedge write_clk);
		#DRIVE_DELAY;
		wr_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, dat: data};
	endtask

	task automatic finish_write(input string name);
		do
		begin
			@(posedge write_clk);
			#DRIVE_DELAY;
		end
		while (!wr_rsp.ack);
		// write port carries no data back
		check_word(name, '0, wr_rsp.dat);
		ref_queue.push_back(wr_req.dat);
		wr_req = '0;
		@(posedge write_clk);
		#DRIVE_DELAY;
		check_flag(name, "wr ack second cycle", 1'b0, wr_rsp.ack);
	endtask

	task automatic start_read();
		@(posedge read_clk);
		#DRIVE_DELAY;
		rd_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, dat: '0};
	endtask

	task automatic finish_read(input string name, output fifo_word_t word);
		do
		begin
			@(posedge read_clk);
			#DRIVE_DELAY;
		end
		while (!rd_rsp.ack);
		word = rd_rsp.dat;
		rd_req = '0;
		@(posedge read_clk);
		#DRIVE_DELAY;
		check_flag(name, "rd ack second cycle", 1'b0, rd_rsp.ack);
	endtask

	// head of the reference queue is the only legal answer
	task automatic compare_pop(input string name, input fifo_word_t word);
		if (ref_queue.size() == 0)
		begin
			$display("%s: read returned %h with nothing left to read", name, word);
			error_count++;
		end
		else
		begin
			check_word(name, ref_queue.pop_front(), word);
		end
	endtask

	task automatic write_word(input string name, input fifo_word_t data);
		start_write(data);
		finish_write(name);
	endtask

	task automatic read_word(input string name);
		fifo_word_t word;
		start_read();
		finish_read(name, word);
		compare_pop(name, word);
	endtask

	//////////////////////////////
	// back-pressure cases
	//////////////////////////////

	// write held off while full until one read frees a slot
	task automatic stall_write(input string name, input fifo_word_t data);
		start_write(data);
		repeat (STALL_CYCLES)
		begin
			@(posedge write_clk);
			#DRIVE_DELAY;
			check_flag(name, "wr ack while full", 1'b0, wr_rsp.ack);
		end
		fork
			finish_write(name);
			read_word(name);
		join
	endtask

	// read held off while empty until one word arrives
	task automatic stall_read(input string name, input fifo_word_t data);
		fifo_word_t word;
		start_read();
		repeat (STALL_CYCLES)
		begin
			@(posedge read_clk);
			#DRIVE_DELAY;
			check_flag(name, "rd ack while empty", 1'b0, rd_rsp.ack);
		end
		fork
			finish_read(name, word);
			write_word(name, data);
		join
		compare_pop(name, word);
	endtask

	task automatic await_flag(input string name, input bit read_side);
		int waited;
		waited = 0;
		while ((read_side ? !empty : !full) && waited < FLAG_BOUND)
		begin
			if (read_side)
			begin
				@(posedge read_clk);
			end
			else
			begin
				@(posedge write_clk);
			end
			#DRIVE_DELAY;
			waited++;
		end
		if (read_side ? !empty : !full)
		begin
			$display("%s: %s did not rise within %0d cycles", name,
				read_side ? "empty" : "full", FLAG_BOUND);
			error_count++;
		end
	endtask

	//////////////////////////////
	// stimulus player
	//////////////////////////////

	task automatic load_stimulus();
		int fd;
		int fields;
		string line;
		string name;
		string cmd;
		fifo_word_t value;
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0)
		begin
			$display("cannot open stimulus file %s", STIM_FILE);
			error_count++;
			return;
		end
		while ($fgets(line, fd) > 0)
		begin
			fields = $sscanf(line, "%s %s %h", name, cmd, value);
			if (line.getc(0) != 8'h23 && fields == 3)
			begin
				stim_names.push_back(name);
				stim_cmds.push_back(cmd);
				stim_values.push_back(value);
				// drain 0 empties whatever is left
				if (cmd == "write" || cmd == "read")
				begin
					total_ops += 1;
				end
				else
				begin
					total_ops += (value == 0) ? 2 * DEPTH : int'(value);
				end
			end
		end
		$fclose(fd);
	endtask

	task automatic run_command(input string name, input string cmd, input fifo_word_t value);
		int count;
		fifo_word_t pick;
		count = int'(value);
		if (cmd == "write")
		begin
			if (ref_queue.size() >= DEPTH)
			begin
				stall_write(name, value);
			end
			else
			begin
				write_word(name, value);
			end
		end
		else if (cmd == "read")
		begin
			if (ref_queue.size() == 0)
			begin
				stall_read(name, value);
			end
			else
			begin
				if (ref_queue[0] != value)
				begin
					$display("%s: stimulus word %h disagrees with queue head %h", name, value,
						ref_queue[0]);
					error_count++;
				end
				read_word(name);
			end
		end
		else if (cmd == "fill")
		begin
			repeat (count)
			begin
				write_word(name, random_bits(32));
			end
			if (ref_queue.size() == DEPTH)
			begin
				await_flag(name, 1'b0);
			end
		end
		else if (cmd == "drain")
		begin
			// drain 0 or a count beyond the held words empties the FIFO
			if (count == 0 || count > ref_queue.size())
			begin
				count = ref_queue.size();
			end
			repeat (count)
			begin
				read_word(name);
			end
			if (ref_queue.size() == 0)
			begin
				await_flag(name, 1'b1);
			end
		end
		else if (cmd == "idle-check")
		begin
			repeat (count)
			begin
				@(posedge write_clk);
				#DRIVE_DELAY;
				check_flag(name, "wr ack while idle", 1'b0, wr_rsp.ack);
				check_flag(name, "rd ack while idle", 1'b0, rd_rsp.ack);
			end
			check_flag(name, "empty", ref_queue.size() == 0, empty);
			check_flag(name, "full", ref_queue.size() == DEPTH, full);
		end
		else if (cmd == "random")
		begin
			repeat (count)
			begin
				pick = random_bits(1);
				if ((pick[0] && ref_queue.size() < DEPTH) || ref_queue.size() == 0)
				begin
					write_word(name, random_bits(32));
				end
				else
				begin
					read_word(name);
				end
			end
		end
		else
		begin
			$display("%s: unknown command %s in stimulus file", name, cmd);
			error_count++;
		end
	endtask

	initial
	begin
		int errors_before;
		int failed_tests;
		wr_req = '0;
		rd_req = '0;
		reset_rsync = 1'b1;
		failed_tests = 0;
		load_stimulus();
		cycle_limit = 40 * total_ops + 200;
		repeat (RESET_CYCLES) @(posedge write_clk);
		#DRIVE_DELAY;
		reset_rsync = 1'b0;
		// read side leaves reset through its own synchronizer
		repeat (SYNC_STAGES + 1) @(posedge read_clk);
		foreach (stim_cmds[i])
		begin
			errors_before = error_count;
			run_command(stim_names[i], stim_cmds[i], stim_values[i]);
			if (error_count == errors_before)
			begin
				$display("test %s: ok", stim_names[i]);
			end
			else
			begin
				$display("test %s: %0d errors", stim_names[i], error_count - errors_before);
				failed_tests++;
			end
		end
		$display("summary: %0d tests, %0d failed, %0d errors", stim_cmds.size(), failed_tests,
			error_count);
		if (error_count == 0)
		begin
			$display("TESTBENCH PASSED");
		end
		else
		begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule
